//--- rtl/axi_rd_burst.sv
/* Frame fetch engine. Reads a frame from memory in AXI bursts of single-byte
   beats and streams each byte with its index to the frame buffer writer. */
`timescale 1ns/10ps
`default_nettype none

module axi_rd_burst
   import axi_rd_pkg::*, eth_frame_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  logic        start_i,
   input  logic [15:0] len_i,
   input  logic [31:0] ptr_i,
   output axi_ar_t     axi_ar_o,
   input  logic        axi_arready_i,
   input  axi_r_t      axi_r_i,
   output logic        axi_rready_o,
   output frame_byte_t byte_o,
   output logic        done_o
);

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      ADDR,
      DATA
   } state_e;

   state_e      state_q;
   logic [15:0] len_q;
   logic [31:0] ptr_q;
   logic [15:0] idx_q;
   logic [15:0] remain;
   logic [15:0] burst_len;
   logic [31:0] byte_addr;
   logic        beat_ok;
   logic [7:0]  lane_byte;

   assign remain = len_q - idx_q;
   assign burst_len = (remain > 16'(AXI_MAX_BURST)) ? 16'(AXI_MAX_BURST) : remain;
   assign byte_addr = ptr_q + 32'(idx_q);
   assign beat_ok = axi_r_i.rvalid && axi_rready_o;

   // Byte sits in the lane picked by the low address bits
   assign lane_byte = axi_r_i.rdata[byte_addr[1:0]*8 +: 8];
   assign byte_o = '{valid: beat_ok, idx: idx_q, data: lane_byte};

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q <= IDLE;
         axi_ar_o.arvalid <= 1'b0;
         axi_rready_o <= 1'b0;
         done_o <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  len_q <= len_i;
                  ptr_q <= ptr_i;
                  idx_q <= '0;
                  state_q <= ISSUE;
               end
            end
            ISSUE: begin
               if (remain == 16'd0) begin
                  done_o <= 1'b1;
                  state_q <= IDLE;
               end else begin
                  axi_ar_o.arvalid <= 1'b1;
                  axi_ar_o.araddr <= byte_addr;
                  axi_ar_o.arlen <= AXI_LEN_W'(burst_len - 16'd1);
                  state_q <= ADDR;
               end
            end
            ADDR: begin
               if (axi_arready_i) begin
                  axi_ar_o.arvalid <= 1'b0;
                  axi_rready_o <= 1'b1;
                  state_q <= DATA;
               end
            end
            DATA: begin
               if (beat_ok) begin
                  idx_q <= idx_q + 16'd1;
                  // Next address phase or frame end decided in ISSUE
                  if (axi_r_i.rlast) begin
                     axi_rready_o <= 1'b0;
                     state_q <= ISSUE;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   a_ar_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      axi_ar_o.arvalid && !axi_arready_i |=> axi_ar_o.arvalid
         && $stable(axi_ar_o.araddr) && $stable(axi_ar_o.arlen));

endmodule

`default_nettype wire

//--- rtl/axi_rd_pkg.sv
/* AXI read channel types and burst limits used by the frame fetch engine.
   Bursts are single-byte beats, so arsize and arburst are fixed by the protocol. */
`default_nettype none

package axi_rd_pkg;

   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W = 8;
   localparam int AXI_MAX_BURST = 16;

   typedef struct packed {
      logic                 arvalid;
      logic [31:0]          araddr;
      logic [AXI_LEN_W-1:0] arlen;
   } axi_ar_t;

   typedef struct packed {
      logic                  rvalid;
      logic [AXI_DATA_W-1:0] rdata;
      logic                  rlast;
   } axi_r_t;

endpackage

`default_nettype wire

//--- rtl/eth_frame_pkg.sv
/* Ethernet frame constants and descriptor types for the transmit DMA engine.
   Descriptor RAM words are read through bd_word_u, control or pointer view. */
`default_nettype none

package eth_frame_pkg;

   localparam int PREAMBLE_LEN = 7;
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE = 8'hD5;
   // First payload byte follows preamble and SFD
   localparam int PRE_FRAME_LEN = PREAMBLE_LEN + 1;
   localparam int NBYTES_W = 11;

   // Descriptor control word, even RAM address
   typedef struct packed {
      logic [15:0] len;
      logic        ready;
      logic        irq;
      logic        wrap;
      logic        rsvd_12;
      logic        crc;
      logic [10:0] rsvd_10_0;
   } bd_ctrl_t;

   typedef union packed {
      bd_ctrl_t    ctrl;
      logic [31:0] ptr;
   } bd_word_u;

   typedef enum logic [1:0] {
      BD_IDLE,
      BD_RD_CTRL,
      BD_RD_PTR,
      BD_WR_STATUS
   } bd_op_e;

   typedef struct packed {
      logic       en;
      logic       wen;
      logic [7:0] addr;
      bd_word_u   wdata;
   } bd_ram_req_t;

   typedef struct packed {
      logic        wen;
      logic [10:0] addr;
      logic [7:0]  data;
   } buf_wr_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] idx;
      logic [7:0]  data;
   } frame_byte_t;

endpackage

`default_nettype wire

//--- rtl/eth_tx_dma.sv
/* Transmit-only Ethernet DMA top level. Connects the sequencer to the descriptor
   port, the AXI frame fetch engine and the frame buffer writer. */
`timescale 1ns/10ps
`default_nettype none

module eth_tx_dma
   import eth_frame_pkg::*, axi_rd_pkg::*;
#(
   parameter int BD_ADDR_W = 8,
   parameter int BUFFER_W  = 11
) (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                tx_en_i,
   output bd_ram_req_t         bd_ram_req_o,
   input  bd_word_u            bd_rdata_i,
   output axi_ar_t             axi_ar_o,
   input  logic                axi_arready_i,
   input  axi_r_t              axi_r_i,
   output logic                axi_rready_o,
   output buf_wr_t             buf_wr_o,
   input  logic                tx_ready_i,
   output logic                send_o,
   output logic [NBYTES_W-1:0] tx_nbytes_o,
   output logic                crc_en_o,
   output logic                tx_irq_o
);

   bd_op_e      bd_op;
   logic        advance;
   logic        fetch_start;
   logic        fetch_done;
   logic        fill_done;
   bd_ctrl_t    desc;
   logic [31:0] frame_ptr;
   frame_byte_t frame_byte;

   tx_dma_ctrl i_tx_dma_ctrl (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .tx_en_i      (tx_en_i),
      .tx_ready_i   (tx_ready_i),
      .fill_done_i  (fill_done),
      .desc_i       (desc),
      .bd_op_o      (bd_op),
      .advance_o    (advance),
      .fetch_start_o(fetch_start),
      .fetch_done_i (fetch_done),
      .send_o       (send_o),
      .tx_nbytes_o  (tx_nbytes_o),
      .crc_en_o     (crc_en_o),
      .tx_irq_o     (tx_irq_o)
   );

   tx_bd_port #(
      .BD_ADDR_W(BD_ADDR_W)
   ) i_tx_bd_port (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .bd_op_i     (bd_op),
      .advance_i   (advance),
      .bd_rdata_i  (bd_rdata_i),
      .bd_ram_req_o(bd_ram_req_o),
      .desc_o      (desc),
      .ptr_o       (frame_ptr)
   );

   axi_rd_burst i_axi_rd_burst (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .start_i      (fetch_start),
      .len_i        (desc.len),
      .ptr_i        (frame_ptr),
      .axi_ar_o     (axi_ar_o),
      .axi_arready_i(axi_arready_i),
      .axi_r_i      (axi_r_i),
      .axi_rready_o (axi_rready_o),
      .byte_o       (frame_byte),
      .done_o       (fetch_done)
   );

   frame_buf_writer #(
      .BUFFER_W(BUFFER_W)
   ) i_frame_buf_writer (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .byte_i     (frame_byte),
      .fill_done_o(fill_done),
      .buf_wr_o   (buf_wr_o)
   );

endmodule

`default_nettype wire

//--- rtl/frame_buf_writer.sv
/* Frame buffer write port. Fills the preamble and SFD after reset, then
   registers each fetched payload byte into the slot after the SFD. */
`timescale 1ns/10ps
`default_nettype none

module frame_buf_writer
   import eth_frame_pkg::*;
#(
   parameter int BUFFER_W = 11
) (
   input  logic        clk_i,
   input  logic        arst_i,
   input  frame_byte_t byte_i,
   output logic        fill_done_o,
   output buf_wr_t     buf_wr_o
);

   localparam int FILL_W = $clog2(PRE_FRAME_LEN + 1);

   logic [FILL_W-1:0]   fill_cnt_q;
   logic [BUFFER_W-1:0] pay_addr;

   assign fill_done_o = (fill_cnt_q == FILL_W'(PRE_FRAME_LEN));
   assign pay_addr = BUFFER_W'(PRE_FRAME_LEN) + byte_i.idx[BUFFER_W-1:0];

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         fill_cnt_q <= '0;
         buf_wr_o.wen <= 1'b0;
      end else if (!fill_done_o) begin
         // Seven preamble bytes, SFD in the last slot
         buf_wr_o.wen <= 1'b1;
         buf_wr_o.addr <= BUFFER_W'(fill_cnt_q);
         buf_wr_o.data <= (fill_cnt_q == FILL_W'(PREAMBLE_LEN)) ? SFD_BYTE : PREAMBLE_BYTE;
         fill_cnt_q <= fill_cnt_q + 1'b1;
      end else begin
         buf_wr_o.wen <= byte_i.valid;
         buf_wr_o.addr <= pay_addr;
         buf_wr_o.data <= byte_i.data;
      end
   end

   a_no_byte_before_fill: assert property (@(posedge clk_i) disable iff (arst_i)
      byte_i.valid |-> fill_done_o);

endmodule

`default_nettype wire

//--- rtl/tx_bd_port.sv
/* Descriptor RAM port of the transmit DMA. Tracks the ring position, captures
   the control word and frame pointer, and writes back the status word. */
`timescale 1ns/10ps
`default_nettype none

module tx_bd_port
   import eth_frame_pkg::*;
#(
   parameter int BD_ADDR_W = 8
) (
   input  logic        clk_i,
   input  logic        arst_i,
   input  bd_op_e      bd_op_i,
   input  logic        advance_i,
   input  bd_word_u    bd_rdata_i,
   output bd_ram_req_t bd_ram_req_o,
   output bd_ctrl_t    desc_o,
   output logic [31:0] ptr_o
);

   logic [BD_ADDR_W-2:0] bd_num_q;
   logic [BD_ADDR_W-1:0] bd_addr;
   logic                 rd_ctrl_q;
   logic                 rd_ptr_q;
   bd_ctrl_t             desc_q;
   logic [31:0]          ptr_q;
   bd_ctrl_t             status;

   // Two words per descriptor, pointer at the odd address
   assign bd_addr = {bd_num_q, bd_op_i == BD_RD_PTR};

   always_comb begin
      status = desc_q;
      status.ready = 1'b0;
      bd_ram_req_o.en = (bd_op_i != BD_IDLE);
      bd_ram_req_o.wen = (bd_op_i == BD_WR_STATUS);
      bd_ram_req_o.addr = bd_addr;
      bd_ram_req_o.wdata.ctrl = status;
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         bd_num_q <= '0;
         rd_ctrl_q <= 1'b0;
         rd_ptr_q <= 1'b0;
      end else begin
         rd_ctrl_q <= (bd_op_i == BD_RD_CTRL);
         rd_ptr_q <= (bd_op_i == BD_RD_PTR);
         if (advance_i) begin
            // Wrap bit or last entry returns to the ring start
            if (desc_q.wrap || (&bd_num_q)) bd_num_q <= '0;
            else bd_num_q <= bd_num_q + 1'b1;
         end
      end
   end

   // RAM data is valid the cycle after the read request
   always_ff @(posedge clk_i) begin
      if (rd_ctrl_q) desc_q <= bd_rdata_i.ctrl;
      if (rd_ptr_q) ptr_q <= bd_rdata_i.ptr;
   end

   assign desc_o = desc_q;
   assign ptr_o = ptr_q;

endmodule

`default_nettype wire

//--- rtl/tx_dma_ctrl.sv
/* Transmit DMA sequencer. Waits for the preamble fill, polls the descriptor ring,
   starts the frame fetch, hands the frame to the transmitter and writes status. */
`timescale 1ns/10ps
`default_nettype none

module tx_dma_ctrl
   import eth_frame_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                tx_en_i,
   input  logic                tx_ready_i,
   input  logic                fill_done_i,
   input  bd_ctrl_t            desc_i,
   output bd_op_e              bd_op_o,
   output logic                advance_o,
   output logic                fetch_start_o,
   input  logic                fetch_done_i,
   output logic                send_o,
   output logic [NBYTES_W-1:0] tx_nbytes_o,
   output logic                crc_en_o,
   output logic                tx_irq_o
);

   typedef enum logic [3:0] {
      S_FILL,
      S_RD_CTRL,
      S_CTRL_WAIT,
      S_CHECK,
      S_RD_PTR,
      S_PTR_WAIT,
      S_TX_WAIT,
      S_FETCH,
      S_SEND,
      S_RELEASE,
      S_WR_STATUS
   } state_e;

   state_e state_q;

   always_comb begin
      bd_op_o = BD_IDLE;
      case (state_q)
         S_RD_CTRL:   bd_op_o = BD_RD_CTRL;
         S_RD_PTR:    bd_op_o = BD_RD_PTR;
         S_WR_STATUS: bd_op_o = BD_WR_STATUS;
         default: ;
      endcase
   end

   // Status write and ring step share the cycle
   assign advance_o = (state_q == S_WR_STATUS);
   assign fetch_start_o = (state_q == S_TX_WAIT) && tx_ready_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q <= S_FILL;
         send_o <= 1'b0;
         crc_en_o <= 1'b0;
         tx_irq_o <= 1'b0;
      end else begin
         tx_irq_o <= 1'b0;
         case (state_q)
            S_FILL: if (fill_done_i) state_q <= S_RD_CTRL;
            S_RD_CTRL: state_q <= S_CTRL_WAIT;
            S_CTRL_WAIT: state_q <= S_CHECK;
            // Not ready or disabled, poll the same descriptor again
            S_CHECK: state_q <= (desc_i.ready && tx_en_i) ? S_RD_PTR : S_RD_CTRL;
            S_RD_PTR: state_q <= S_PTR_WAIT;
            S_PTR_WAIT: state_q <= S_TX_WAIT;
            S_TX_WAIT: if (tx_ready_i) state_q <= S_FETCH;
            S_FETCH: if (fetch_done_i) state_q <= S_SEND;
            S_SEND: begin
               if (tx_ready_i) begin
                  send_o <= 1'b1;
                  tx_nbytes_o <= NBYTES_W'(PRE_FRAME_LEN) + desc_i.len[NBYTES_W-1:0];
                  crc_en_o <= desc_i.crc;
                  state_q <= S_RELEASE;
               end
            end
            // Transmitter took the frame once ready drops
            S_RELEASE: begin
               if (!tx_ready_i) begin
                  send_o <= 1'b0;
                  tx_irq_o <= desc_i.irq;
                  state_q <= S_WR_STATUS;
               end
            end
            S_WR_STATUS: state_q <= S_RD_CTRL;
            default: state_q <= S_FILL;
         endcase
      end
   end

   a_send_needs_ready: assert property (@(posedge clk_i) disable iff (arst_i)
      $rose(send_o) |-> $past(tx_ready_i));

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
/* Free-running testbench clock, 4 ns period by default.
   Instantiated once by the testbench top. */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- sim/tb_eth_tx_dma.sv
/* Testbench top for the transmit DMA. Loads descriptors from the vectors file,
   runs the ring and checks fill, fetch, send and status writeback. */
`timescale 1ns/10ps
`default_nettype none

module tb_eth_tx_dma
   import eth_frame_pkg::*, axi_rd_pkg::*;
();

   localparam int MEM_BYTES = 4096;

   logic                clk;
   logic                arst_i = 1'b1;
   logic                tx_en_i = 1'b1;
   logic                tx_en_want = 1'b1;
   logic                tx_ready_i = 1'b1;
   bd_ram_req_t         bd_ram_req;
   bd_word_u            bd_rdata;
   axi_ar_t             axi_ar;
   logic                axi_arready;
   axi_r_t              axi_r;
   logic                axi_rready;
   buf_wr_t             buf_wr;
   logic                send_o;
   logic [NBYTES_W-1:0] tx_nbytes;
   logic                crc_en;
   logic                tx_irq;

   int          f_idx[$], f_len[$], f_irq[$], f_wrap[$], f_crc[$], f_ptr[$];
   int          f_hold[$], f_engap[$];
   int          cur_len, cur_ptr, cur_irq, cur_crc, exp_idx;
   logic [31:0] cur_ctrl;
   int          wr_cnt, ar_bytes, wb_cnt, wd_limit;
   bit          send_seen, send_prev, gate, payload_on;
   logic [2:0]  txc;

   tb_clk_gen i_clk_gen (.clk_o(clk));

   eth_tx_dma i_eth_tx_dma (
      .clk_i(clk), .arst_i(arst_i), .tx_en_i(tx_en_i),
      .bd_ram_req_o(bd_ram_req), .bd_rdata_i(bd_rdata),
      .axi_ar_o(axi_ar), .axi_arready_i(axi_arready), .axi_r_i(axi_r),
      .axi_rready_o(axi_rready), .buf_wr_o(buf_wr), .tx_ready_i(tx_ready_i),
      .send_o(send_o), .tx_nbytes_o(tx_nbytes), .crc_en_o(crc_en), .tx_irq_o(tx_irq)
   );

   tb_mem_models i_mem (
      .clk_i(clk), .arst_i(arst_i), .bd_ram_req_i(bd_ram_req), .bd_rdata_o(bd_rdata),
      .axi_ar_i(axi_ar), .axi_arready_o(axi_arready), .axi_r_o(axi_r),
      .axi_rready_i(axi_rready)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
         abort_run("First failing check stops the run");
      end
   endtask

   function automatic logic [31:0] ctrl_word(input int k, input bit rdy);
      return {f_len[k][15:0], rdy, f_irq[k][0], f_wrap[k][0], 1'b0, f_crc[k][0], 11'd0};
   endfunction

   task automatic load_vectors();
      int fd, code, idx, len, irq, wrap, crc, ptr, cnt, hold, engap;
      string line;
      fd = $fopen("sim/tx_dma_vectors.txt", "r");
      if (fd == 0) abort_run("Cannot open sim/tx_dma_vectors.txt");
      while (!$feof(fd)) begin
         line = "";
         code = $fgets(line, fd);
         if (line.len() == 0 || line.substr(0, 0) == "#") continue;
         code = $sscanf(line, "%d %d %d %d %d %h %d %d %d",
                        idx, len, irq, wrap, crc, ptr, cnt, hold, engap);
         if (code != 9) continue;
         // A count above one expands into consecutive descriptors
         for (int n = 0; n < cnt; n++) begin
            f_idx.push_back(idx + n);
            f_len.push_back(len);
            f_irq.push_back(irq);
            f_wrap.push_back(wrap);
            f_crc.push_back(crc);
            f_ptr.push_back(ptr + n * len);
            f_hold.push_back(hold);
            f_engap.push_back(engap);
         end
      end
      $fclose(fd);
   endtask

   // Model transmitter drops ready a few cycles into send
   always @(posedge clk) begin
      if (arst_i) begin
         tx_ready_i <= 1'b1;
         txc <= '0;
      end else if (tx_ready_i) begin
         if (send_o) begin
            txc <= (txc == 3'd3) ? 3'd0 : txc + 3'd1;
            if (txc == 3'd3) tx_ready_i <= 1'b0;
         end
      end else begin
         txc <= (txc == 3'd2) ? 3'd0 : txc + 3'd1;
         if (txc == 3'd2) tx_ready_i <= 1'b1;
      end
   end

   always @(posedge clk) tx_en_i <= tx_en_want;

   always @(negedge clk) begin
      int burst;
      if (!arst_i && payload_on) begin
         if (buf_wr.wen) begin
            check_value(buf_wr.addr, PRE_FRAME_LEN + wr_cnt, "payload address");
            check_value(buf_wr.data, i_mem.byte_mem[(cur_ptr + wr_cnt) % MEM_BYTES],
                        "payload byte");
            wr_cnt++;
         end
         if (axi_ar.arvalid) check_value(gate, 0, "AXI request while frame gated");
         if (axi_ar.arvalid && axi_arready) begin
            burst = (cur_len - ar_bytes > AXI_MAX_BURST) ? AXI_MAX_BURST : cur_len - ar_bytes;
            check_value(axi_ar.araddr, 32'(cur_ptr + ar_bytes), "araddr");
            check_value(axi_ar.arlen, burst - 1, "arlen");
            ar_bytes += burst;
         end
         if (send_o && !send_prev) begin
            check_value(tx_nbytes, (PRE_FRAME_LEN + cur_len) % 2048, "tx_nbytes");
            check_value(crc_en, cur_crc, "crc_en");
            check_value(wr_cnt, cur_len, "bytes written before send");
            send_seen = 1'b1;
         end
         if (bd_ram_req.en && bd_ram_req.wen) begin
            check_value(send_seen, 1, "status write before send");
            check_value(send_o, 0, "send still high at status write");
            check_value(bd_ram_req.addr, 2 * exp_idx, "status write address");
            check_value(bd_ram_req.wdata, cur_ctrl & ~32'h8000, "status word");
            check_value(tx_irq, cur_irq, "irq with status write");
            wb_cnt++;
         end else begin
            check_value(tx_irq, 0, "irq without status write");
         end
      end
      send_prev = send_o;
   end

   initial begin
      wait (wd_limit != 0);
      repeat (wd_limit) @(posedge clk);
      abort_run("Timeout, the DMA did not finish all frames in time");
   end

   initial begin
      int idx, gmax, sum_len;
      wd_limit = 0;
      wb_cnt = 0;
      payload_on = 1'b0;
      gate = 1'b0;
      void'($urandom(32'h84b1_92d1));
      for (int a = 0; a < MEM_BYTES; a++) i_mem.byte_mem[a] = 8'($urandom);
      for (int a = 0; a < 256; a++) i_mem.bd_ram[a] = '0;
      load_vectors();
      if (f_idx.size() == 0) abort_run("No descriptors found in vectors file");
      sum_len = 0;
      foreach (f_idx[k]) begin
         sum_len += f_len[k];
         if (f_hold[k] == 0) begin
            i_mem.bd_ram[2 * f_idx[k]] = ctrl_word(k, 1'b1);
            i_mem.bd_ram[2 * f_idx[k] + 1] = f_ptr[k];
         end
      end
      wd_limit = sum_len * 20 + 1000;
      repeat (8) @(posedge clk);
      arst_i <= 1'b0;
      @(posedge clk);
      // Preamble and SFD fill right after reset
      for (int j = 0; j < PRE_FRAME_LEN; j++) begin
         @(negedge clk);
         check_value(buf_wr.wen, 1, "fill write enable");
         check_value(buf_wr.addr, j, "fill address");
         check_value(buf_wr.data, (j == PRE_FRAME_LEN - 1) ? 8'hD5 : 8'h55, "fill byte");
      end
      @(posedge clk);
      payload_on = 1'b1;
      idx = 0;
      foreach (f_idx[k]) begin
         exp_idx = idx;
         cur_len = f_len[k];
         cur_ptr = f_ptr[k];
         cur_irq = f_irq[k];
         cur_crc = f_crc[k];
         cur_ctrl = ctrl_word(k, 1'b1);
         wr_cnt = 0;
         ar_bytes = 0;
         send_seen = 1'b0;
         if (f_hold[k] != 0) begin
            i_mem.bd_ram[2 * f_idx[k]] = ctrl_word(k, 1'b0);
            i_mem.bd_ram[2 * f_idx[k] + 1] = f_ptr[k];
         end
         if (f_engap[k] != 0) tx_en_want = 1'b0;
         gmax = (f_hold[k] > f_engap[k]) ? f_hold[k] : f_engap[k];
         gate = (gmax != 0);
         for (int c = 0; c < gmax; c++) begin
            @(negedge clk);
            if (c + 1 == f_hold[k]) i_mem.bd_ram[2 * f_idx[k]] = ctrl_word(k, 1'b1);
            if (c + 1 == f_engap[k]) tx_en_want = 1'b1;
         end
         gate = 1'b0;
         while (wb_cnt != k + 1) @(negedge clk);
         // Ring wraps to 0 after the wrap bit or the last entry
         idx = (f_wrap[k] != 0 || idx == 127) ? 0 : idx + 1;
      end
      repeat (4) @(negedge clk);
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/tb_mem_models.sv
/* Descriptor RAM and AXI read memory models for the transmit DMA testbench.
   The AXI responder inserts random arready and rvalid gaps. */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_models
   import eth_frame_pkg::*, axi_rd_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  bd_ram_req_t bd_ram_req_i,
   output bd_word_u    bd_rdata_o,
   input  axi_ar_t     axi_ar_i,
   output logic        axi_arready_o,
   output axi_r_t      axi_r_o,
   input  logic        axi_rready_i
);

   localparam int MEM_BYTES = 4096;

   logic [31:0] bd_ram [256];
   logic [7:0]  byte_mem [MEM_BYTES];
   logic        busy_q;
   logic [31:0] addr_q;
   logic [8:0]  left_q;

   initial begin
      bd_rdata_o = '0;
      axi_arready_o = 1'b0;
      axi_r_o = '0;
   end

   // Read data one cycle after the request, write on the request cycle
   always @(posedge clk_i) begin
      if (bd_ram_req_i.en) begin
         if (bd_ram_req_i.wen) bd_ram[bd_ram_req_i.addr] <= bd_ram_req_i.wdata;
         else bd_rdata_o <= bd_ram[bd_ram_req_i.addr];
      end
   end

   // Byte goes to lane a[1:0], other lanes carry noise
   task automatic present_beat(input logic [31:0] a, input logic [8:0] left);
      logic [31:0] word;
      word = $urandom;
      word[a[1:0]*8 +: 8] = byte_mem[a % MEM_BYTES];
      if ($urandom_range(3, 0) != 0) begin
         axi_r_o.rvalid <= 1'b1;
         axi_r_o.rdata <= word;
         axi_r_o.rlast <= (left == 9'd1);
      end else begin
         axi_r_o.rvalid <= 1'b0;
      end
   endtask

   always @(posedge clk_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         axi_arready_o <= 1'b0;
         axi_r_o <= '0;
      end else if (!busy_q) begin
         if (axi_ar_i.arvalid && axi_arready_o) begin
            busy_q <= 1'b1;
            addr_q <= axi_ar_i.araddr;
            left_q <= 9'(axi_ar_i.arlen) + 9'd1;
            axi_arready_o <= 1'b0;
         end else begin
            axi_arready_o <= ($urandom_range(2, 0) != 0);
         end
      end else if (axi_r_o.rvalid && axi_rready_i) begin
         if (left_q == 9'd1) begin
            busy_q <= 1'b0;
            axi_r_o.rvalid <= 1'b0;
         end else begin
            present_beat(addr_q + 32'd1, left_q - 9'd1);
         end
         addr_q <= addr_q + 32'd1;
         left_q <= left_q - 9'd1;
      end else if (!axi_r_o.rvalid) begin
         present_beat(addr_q, left_q);
      end
   end

endmodule

`default_nettype wire

//--- sim/tx_dma_vectors.txt
# idx len irq wrap crc ptr(hex) count hold engap
# count expands to consecutive descriptors, hold delays ready, engap drops tx_en
0 40 1 0 1 0101 1 0 0
1 17 0 0 0 0202 1 0 8
2 2 0 0 1 0300 125 0 0
127 21 1 0 0 0400 1 0 0
0 33 0 0 1 0501 1 12 0
1 5 1 1 1 0603 1 6 10
0 16 1 0 0 0700 1 4 0

//--- vlog.f
rtl/eth_frame_pkg.sv
rtl/axi_rd_pkg.sv
rtl/tx_dma_ctrl.sv
rtl/tx_bd_port.sv
rtl/axi_rd_burst.sv
rtl/frame_buf_writer.sv
rtl/eth_tx_dma.sv
sim/tb_clk_gen.sv
sim/tb_mem_models.sv
sim/tb_eth_tx_dma.sv
